// File: tb.f
+incdir+hdl
hdl/ne_stream_pkg.sv
hdl/ne_cell_pkg.sv
hdl/row_controller.sv
hdl/row_bank_store.sv
hdl/conv_cell.sv
hdl/maxpool_cell.sv
hdl/result_fifo.sv
hdl/net_engine_top.sv
bench/net_engine_checker.sv
bench/net_engine_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module net_engine_tb -f tb.f -o Vnet_engine_tb

./obj_dir/Vnet_engine_tb | tee sim.log

if grep -q "TEST FAIL" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
echo "Simulation finished without failure"

// File: bench/net_engine_tb.sv
`default_nettype none

`include "ne_settings.svh"

module net_engine_tb
	import ne_stream_pkg::*, ne_cell_pkg::*;
();

	localparam int ROW_W = `NE_ROW_WIDTH;
	localparam int K = `NE_KERNEL_SIZE;
	localparam int WINS = `NE_ROW_WIDTH - `NE_KERNEL_SIZE + 1;   // Results per output row
	localparam int NUM_FRAMES = 5;
	localparam int MAX_ROWS = 12;
	localparam int RESET_CYCLES = 8;

	logic       S_AXIS_ACLK;
	logic       S_AXIS_ARESETN;
	pixel_t     s_axis_tdata;
	logic       s_axis_tvalid;
	logic       s_axis_tlast;
	logic       s_axis_tready;
	pixel_t     m_axis_tdata;
	logic       m_axis_tvalid;
	logic       m_axis_tlast;
	logic       m_axis_tready;
	cell_mode_t cell_mode;
	coeff_t     bias;
	kernel_t    kernel;

	// Frame table
	cell_mode_t tbl_mode [NUM_FRAMES] = '{CELL_CONV, CELL_POOL, CELL_CONV, CELL_POOL, CELL_CONV};
	int         tbl_rows [NUM_FRAMES] = '{3, 5, 12, 10, 4};
	logic       tbl_rand_ready [NUM_FRAMES] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
	coeff_t     tbl_bias [NUM_FRAMES] = '{32'sd7, 32'sd0, -32'sd1000, 32'sd0, 32'sh4000_0000};
	kernel_t    tbl_kernel [NUM_FRAMES] = '{
		'{32'sd1, -32'sd2, 32'sd3, -32'sd4, 32'sd5, -32'sd6, 32'sd7, -32'sd8, 32'sd9},
		'0,
		'{32'sh7fff_ffff, 32'sd3, -32'sd1, 32'sd0, 32'sh8000_0001, 32'sd17,
			-32'sd100, 32'sd2, 32'sh1234_5678},
		'0,
		'{32'sd0, 32'sd0, 32'sd0, 32'sd0, 32'sd1, 32'sd0, 32'sd0, 32'sd0, -32'sd1}
	};

	logic [31:0] lfsr_state = 32'h70aca7f5;
	pixel_t      frame_pix [MAX_ROWS][ROW_W];
	pixel_t      exp_data [$];
	logic        exp_last [$];
	int          data_errors = 0;
	int          last_errors = 0;
	int          state_errors = 0;
	int          other_errors = 0;

	net_engine_top net_engine_top_inst (
		.S_AXIS_ACLK   (S_AXIS_ACLK),
		.S_AXIS_ARESETN(S_AXIS_ARESETN),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tlast  (s_axis_tlast),
		.s_axis_tready (s_axis_tready),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tlast  (m_axis_tlast),
		.m_axis_tready (m_axis_tready),
		.cell_mode     (cell_mode),
		.bias          (bias),
		.kernel        (kernel)
	);

	initial begin
		S_AXIS_ACLK = 1'b0;
		forever #20 S_AXIS_ACLK = ~S_AXIS_ACLK;
	end

	// x^32 + x^22 + x^2 + x + 1 stepped once per bit
	function automatic logic [31:0] lfsr_take(input int nbits);
		logic [31:0] bits;
		logic        fb;
		bits = '0;
		for (int i = 0; i < nbits; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			bits = {bits[30:0], fb};
		end
		return bits;
	endfunction

	function automatic int cycle_limit_from_table();
		int beats;
		beats = 0;
		for (int f = 0; f < NUM_FRAMES; f++)
			beats += tbl_rows[f] * ROW_W + (tbl_rows[f] - 2) * WINS;
		return 8 * beats + 20 * RESET_CYCLES;   // Random ready roughly halves throughput
	endfunction

	// Reference reduction of the window whose top left pixel is (r, c)
	function automatic pixel_t window_result(input int f, input int r, input int c);
		pixel_t acc;
		pixel_t px;
		longint prod;
		acc = (tbl_mode[f] == CELL_CONV) ? tbl_bias[f] : frame_pix[r][c];
		for (int wr = 0; wr < K; wr++) begin
			for (int wc = 0; wc < K; wc++) begin
				px = frame_pix[r + wr][c + wc];
				if (tbl_mode[f] == CELL_CONV) begin
					prod = longint'(px) * longint'(tbl_kernel[f][wr*K + wc]);
					acc = acc + pixel_t'(prod[31:0]);   // Low word only
				end else if (px > acc) begin
					acc = px;
				end
			end
		end
		return acc;
	endfunction

	task automatic build_frame(input int f);
		for (int r = 0; r < tbl_rows[f]; r++)
			for (int c = 0; c < ROW_W; c++)
				frame_pix[r][c] = lfsr_take(32);
		exp_data.delete();
		exp_last.delete();
		for (int r = 0; r + K <= tbl_rows[f]; r++) begin
			for (int c = 0; c < WINS; c++) begin
				exp_data.push_back(window_result(f, r, c));
				exp_last.push_back(c == WINS - 1);
			end
		end
	endtask

	task automatic send_frame(input int f);
		for (int r = 0; r < tbl_rows[f]; r++) begin
			for (int c = 0; c < ROW_W; c++) begin
				@(posedge S_AXIS_ACLK);
				s_axis_tvalid <= 1'b1;
				s_axis_tdata  <= frame_pix[r][c];
				s_axis_tlast  <= (r == tbl_rows[f] - 1) && (c == ROW_W - 1);
				@(negedge S_AXIS_ACLK);
				while (!s_axis_tready)
					@(negedge S_AXIS_ACLK);   // Accepted on the coming edge
			end
		end
		@(posedge S_AXIS_ACLK);
		s_axis_tvalid <= 1'b0;
		s_axis_tlast  <= 1'b0;
	endtask

	task automatic receive_results(input int f);
		int          idx;
		logic [31:0] ready_bit;
		idx = 0;
		while (idx < exp_data.size()) begin
			@(posedge S_AXIS_ACLK);
			ready_bit = tbl_rand_ready[f] ? lfsr_take(1) : 32'd1;
			m_axis_tready <= ready_bit[0];
			@(negedge S_AXIS_ACLK);
			if (m_axis_tvalid && m_axis_tready) begin
				if (m_axis_tdata !== exp_data[idx]) begin
					$display("FAIL t=%0t m_axis_tdata got %0h expected %0h (frame %0d result %0d)",
						$time, m_axis_tdata, exp_data[idx], f, idx);
					data_errors++;
				end
				if (m_axis_tlast !== exp_last[idx]) begin
					$display("FAIL t=%0t m_axis_tlast got %b expected %b (frame %0d result %0d)",
						$time, m_axis_tlast, exp_last[idx], f, idx);
					last_errors++;
				end
				idx++;
			end
		end
	endtask

	task automatic check_idle(input string when);
		if (m_axis_tvalid !== 1'b0) begin
			$display("FAIL t=%0t m_axis_tvalid got %b expected 0 (%s)", $time, m_axis_tvalid, when);
			state_errors++;
		end
		if (s_axis_tready !== 1'b1) begin
			$display("FAIL t=%0t s_axis_tready got %b expected 1 (%s)", $time, s_axis_tready, when);
			state_errors++;
		end
	endtask

	task automatic finish_run();
		$display("Errors: %0d data, %0d last, %0d state, %0d other",
			data_errors, last_errors, state_errors, other_errors);
		if (data_errors + last_errors + state_errors + other_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	endtask

	initial begin : watchdog
		int limit;
		int cycle_count;
		limit = cycle_limit_from_table();
		cycle_count = 0;
		while (cycle_count < limit) begin
			@(posedge S_AXIS_ACLK);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the DUT stopped moving data", limit);
		other_errors++;
		finish_run();
	end

	initial begin : main
		S_AXIS_ARESETN = 1'b0;
		s_axis_tdata   = '0;
		s_axis_tvalid  = 1'b0;
		s_axis_tlast   = 1'b0;
		m_axis_tready  = 1'b0;
		cell_mode      = CELL_POOL;
		bias           = '0;
		kernel         = '0;

		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge S_AXIS_ACLK);
			if (i == RESET_CYCLES - 1)
				S_AXIS_ARESETN <= 1'b1;
			@(negedge S_AXIS_ACLK);
			check_idle("during reset");
		end
		@(negedge S_AXIS_ACLK);
		check_idle("after reset");

		// Config only changes once the previous frame has drained
		for (int f = 0; f < NUM_FRAMES; f++) begin
			@(posedge S_AXIS_ACLK);
			cell_mode <= tbl_mode[f];
			bias      <= tbl_bias[f];
			kernel    <= tbl_kernel[f];
			build_frame(f);
			fork
				send_frame(f);
				receive_results(f);
			join
		end

		@(posedge S_AXIS_ACLK);
		m_axis_tready <= 1'b1;
		repeat (4 * `NE_PIPE_DEPTH + 8) begin
			@(negedge S_AXIS_ACLK);
			if (m_axis_tvalid) begin
				$display("Result beyond the expected count appeared on the output stream");
				other_errors++;
			end
		end
		finish_run();
	end

endmodule

`default_nettype wire

// File: bench/net_engine_checker.sv
`default_nettype none

module net_engine_checker
	import ne_stream_pkg::*;
(
	input logic   S_AXIS_ACLK,
	input logic   S_AXIS_ARESETN,
	input pixel_t m_axis_tdata,
	input logic   m_axis_tvalid,
	input logic   m_axis_tlast,
	input logic   m_axis_tready,
	input logic   fifo_wr,     // Selected cell result valid
	input logic   fifo_full
);

	// A stalled beat keeps its data and last flag
	output_held: assert property (@(posedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
		(m_axis_tvalid && !m_axis_tready) |=>
			(m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast)))
		else $error("Output stream beat changed or dropped before it was accepted");

	idle_in_reset: assert property (@(posedge S_AXIS_ACLK)
		!S_AXIS_ARESETN |=> !m_axis_tvalid)
		else $error("Output stream valid while in reset");

	// Credit scheme must keep the FIFO from overflowing
	no_write_full: assert property (@(posedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
		fifo_full |-> !fifo_wr)
		else $error("Result written into a full output FIFO");

endmodule

bind net_engine_top net_engine_checker net_engine_checker_inst (
	.S_AXIS_ACLK   (S_AXIS_ACLK),
	.S_AXIS_ARESETN(S_AXIS_ARESETN),
	.m_axis_tdata  (m_axis_tdata),
	.m_axis_tvalid (m_axis_tvalid),
	.m_axis_tlast  (m_axis_tlast),
	.m_axis_tready (m_axis_tready),
	.fifo_wr       (result_fifo_inst.fifo_wr),
	.fifo_full     (result_fifo_inst.fifo_full)
);

`default_nettype wire

// File: hdl/net_engine_top.sv
`default_nettype none

module net_engine_top
	import ne_stream_pkg::*, ne_cell_pkg::*;
(
	input  logic       S_AXIS_ACLK,
	input  logic       S_AXIS_ARESETN,
	input  pixel_t     s_axis_tdata,
	input  logic       s_axis_tvalid,
	input  logic       s_axis_tlast,
	output logic       s_axis_tready,
	output pixel_t     m_axis_tdata,
	output logic       m_axis_tvalid,
	output logic       m_axis_tlast,
	input  logic       m_axis_tready,
	input  cell_mode_t cell_mode,
	input  coeff_t     bias,
	input  kernel_t    kernel
);

	// Row write side
	logic  wr_en;
	bank_t wr_bank;
	col_t  wr_col;

	// Window issue
	logic  win_valid;
	logic  win_last;
	col_t  win_col;
	bank_t win_top_bank;

	window_t window;
	logic    window_valid;
	logic    window_last;

	pixel_t conv_result;
	logic   conv_valid;
	logic   conv_last;
	pixel_t pool_result;
	logic   pool_valid;
	logic   pool_last;

	logic space_ok;   // FIFO credit back to the controller

	row_controller row_controller_inst (
		.S_AXIS_ACLK   (S_AXIS_ACLK),
		.S_AXIS_ARESETN(S_AXIS_ARESETN),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tlast  (s_axis_tlast),
		.s_axis_tready (s_axis_tready),
		.space_ok      (space_ok),
		.wr_en         (wr_en),
		.wr_bank       (wr_bank),
		.wr_col        (wr_col),
		.win_valid     (win_valid),
		.win_last      (win_last),
		.win_col       (win_col),
		.win_top_bank  (win_top_bank)
	);

	row_bank_store row_bank_store_inst (
		.S_AXIS_ACLK   (S_AXIS_ACLK),
		.S_AXIS_ARESETN(S_AXIS_ARESETN),
		.s_axis_tdata  (s_axis_tdata),
		.wr_en         (wr_en),
		.wr_bank       (wr_bank),
		.wr_col        (wr_col),
		.win_valid     (win_valid),
		.win_last      (win_last),
		.win_col       (win_col),
		.win_top_bank  (win_top_bank),
		.window        (window),
		.window_valid  (window_valid),
		.window_last   (window_last)
	);

	conv_cell conv_cell_inst (
		.S_AXIS_ACLK   (S_AXIS_ACLK),
		.S_AXIS_ARESETN(S_AXIS_ARESETN),
		.window        (window),
		.window_valid  (window_valid),
		.window_last   (window_last),
		.kernel        (kernel),
		.bias          (bias),
		.conv_result   (conv_result),
		.conv_valid    (conv_valid),
		.conv_last     (conv_last)
	);

	maxpool_cell maxpool_cell_inst (
		.S_AXIS_ACLK   (S_AXIS_ACLK),
		.S_AXIS_ARESETN(S_AXIS_ARESETN),
		.window        (window),
		.window_valid  (window_valid),
		.window_last   (window_last),
		.pool_result   (pool_result),
		.pool_valid    (pool_valid),
		.pool_last     (pool_last)
	);

	result_fifo result_fifo_inst (
		.S_AXIS_ACLK   (S_AXIS_ACLK),
		.S_AXIS_ARESETN(S_AXIS_ARESETN),
		.cell_mode     (cell_mode),
		.conv_result   (conv_result),
		.conv_valid    (conv_valid),
		.conv_last     (conv_last),
		.pool_result   (pool_result),
		.pool_valid    (pool_valid),
		.pool_last     (pool_last),
		.space_ok      (space_ok),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tlast  (m_axis_tlast),
		.m_axis_tready (m_axis_tready)
	);

endmodule

`default_nettype wire

// File: hdl/result_fifo.sv
`default_nettype none

`include "ne_settings.svh"

module result_fifo
	import ne_stream_pkg::*, ne_cell_pkg::*;
(
	input  logic       S_AXIS_ACLK,
	input  logic       S_AXIS_ARESETN,
	input  cell_mode_t cell_mode,
	input  pixel_t     conv_result,
	input  logic       conv_valid,
	input  logic       conv_last,
	input  pixel_t     pool_result,
	input  logic       pool_valid,
	input  logic       pool_last,
	output logic       space_ok,
	output pixel_t     m_axis_tdata,
	output logic       m_axis_tvalid,
	output logic       m_axis_tlast,
	input  logic       m_axis_tready
);

	localparam int PTR_W = $clog2(`NE_FIFO_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	pixel_t           fifo_data [`NE_FIFO_DEPTH];
	logic             fifo_tlast [`NE_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fifo_count;
	pixel_t           sel_result;
	logic             sel_last;
	logic             fifo_wr;
	logic             fifo_rd;
	logic             fifo_full;
	logic             push;

	always_comb begin
		if (cell_mode == CELL_CONV) begin
			sel_result = conv_result;
			sel_last   = conv_last;
			fifo_wr    = conv_valid;
		end else begin
			sel_result = pool_result;
			sel_last   = pool_last;
			fifo_wr    = pool_valid;
		end
	end

	assign fifo_full = (fifo_count == CNT_W'(`NE_FIFO_DEPTH));
	assign push      = fifo_wr && !fifo_full;
	assign fifo_rd   = m_axis_tvalid && m_axis_tready;

	// Room for every window already in flight plus one more
	assign space_ok = (fifo_count <= CNT_W'(`NE_FIFO_DEPTH - `NE_PIPE_DEPTH - 1));

	assign m_axis_tvalid = (fifo_count != '0);
	assign m_axis_tdata  = fifo_data[rd_ptr];
	assign m_axis_tlast  = m_axis_tvalid && fifo_tlast[rd_ptr];

	always_ff @(posedge S_AXIS_ACLK) begin
		if (push) begin
			fifo_data[wr_ptr]  <= sel_result;
			fifo_tlast[wr_ptr] <= sel_last;
		end
	end

	always_ff @(posedge S_AXIS_ACLK) begin
		if (!S_AXIS_ARESETN) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fifo_count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (fifo_rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !fifo_rd)
				fifo_count <= fifo_count + 1'b1;
			else if (fifo_rd && !push)
				fifo_count <= fifo_count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/maxpool_cell.sv
`default_nettype none

`include "ne_settings.svh"

module maxpool_cell
	import ne_stream_pkg::*;
(
	input  logic    S_AXIS_ACLK,
	input  logic    S_AXIS_ARESETN,
	input  window_t window,
	input  logic    window_valid,
	input  logic    window_last,
	output pixel_t  pool_result,
	output logic    pool_valid,
	output logic    pool_last
);

	localparam int K = `NE_KERNEL_SIZE;

	pixel_t row_max [K];
	logic   row_valid;
	logic   row_last;

	// Signed compare as both sides are pixel_t
	function automatic pixel_t max2(input pixel_t a, input pixel_t b);
		return (a > b) ? a : b;
	endfunction

	always_ff @(posedge S_AXIS_ACLK) begin
		for (int r = 0; r < K; r++) begin
			row_max[r] <= max2(max2(window[r*K], window[r*K + 1]), window[r*K + 2]);
		end
		pool_result <= max2(max2(row_max[0], row_max[1]), row_max[2]);
	end

	always_ff @(posedge S_AXIS_ACLK) begin
		if (!S_AXIS_ARESETN) begin
			row_valid  <= 1'b0;
			row_last   <= 1'b0;
			pool_valid <= 1'b0;
			pool_last  <= 1'b0;
		end else begin
			row_valid  <= window_valid;
			row_last   <= window_last;
			pool_valid <= row_valid;
			pool_last  <= row_last;
		end
	end

endmodule

`default_nettype wire

// File: hdl/conv_cell.sv
`default_nettype none

`include "ne_settings.svh"

module conv_cell
	import ne_stream_pkg::*, ne_cell_pkg::*;
(
	input  logic    S_AXIS_ACLK,
	input  logic    S_AXIS_ARESETN,
	input  window_t window,
	input  logic    window_valid,
	input  logic    window_last,
	input  kernel_t kernel,
	input  coeff_t  bias,
	output pixel_t  conv_result,
	output logic    conv_valid,
	output logic    conv_last
);

	localparam int TAPS = `NE_KERNEL_SIZE * `NE_KERNEL_SIZE;

	pixel_t product [TAPS];   // Low word of each product
	pixel_t tap_sum;
	logic   prod_valid;
	logic   prod_last;

	always_ff @(posedge S_AXIS_ACLK) begin
		for (int i = 0; i < TAPS; i++) begin
			product[i] <= pixel_t'(window[i] * kernel[i]);
		end
	end

	// Wraps modulo 2**32 like the products
	always_comb begin
		tap_sum = bias;
		for (int i = 0; i < TAPS; i++) begin
			tap_sum = tap_sum + product[i];
		end
	end

	always_ff @(posedge S_AXIS_ACLK)
		conv_result <= tap_sum;

	always_ff @(posedge S_AXIS_ACLK) begin
		if (!S_AXIS_ARESETN) begin
			prod_valid <= 1'b0;
			prod_last  <= 1'b0;
			conv_valid <= 1'b0;
			conv_last  <= 1'b0;
		end else begin
			prod_valid <= window_valid;
			prod_last  <= window_last;
			conv_valid <= prod_valid;
			conv_last  <= prod_last;
		end
	end

endmodule

`default_nettype wire

// File: hdl/row_bank_store.sv
`default_nettype none

`include "ne_settings.svh"

module row_bank_store
	import ne_stream_pkg::*;
(
	input  logic    S_AXIS_ACLK,
	input  logic    S_AXIS_ARESETN,
	input  pixel_t  s_axis_tdata,
	input  logic    wr_en,
	input  bank_t   wr_bank,
	input  col_t    wr_col,
	input  logic    win_valid,
	input  logic    win_last,
	input  col_t    win_col,
	input  bank_t   win_top_bank,
	output window_t window,
	output logic    window_valid,
	output logic    window_last
);

	localparam int K = `NE_KERNEL_SIZE;

	pixel_t row_mem [`NE_ROW_BANKS][`NE_ROW_WIDTH];

	always_ff @(posedge S_AXIS_ACLK) begin
		if (wr_en)
			row_mem[wr_bank][wr_col] <= s_axis_tdata;
	end

	// Three consecutive banks from the top wrap past the last bank
	always_ff @(posedge S_AXIS_ACLK) begin
		if (win_valid) begin
			for (int r = 0; r < K; r++) begin
				for (int c = 0; c < K; c++) begin
					window[r*K + c] <=
						row_mem[bank_t'(win_top_bank + 2'(r))][col_t'(win_col + 3'(c))];
				end
			end
		end
	end

	always_ff @(posedge S_AXIS_ACLK) begin
		if (!S_AXIS_ARESETN) begin
			window_valid <= 1'b0;
			window_last  <= 1'b0;
		end else begin
			window_valid <= win_valid;
			window_last  <= win_last;   // Last window of the pass
		end
	end

endmodule

`default_nettype wire

// File: hdl/row_controller.sv
`default_nettype none

`include "ne_settings.svh"

module row_controller
	import ne_stream_pkg::*;
(
	input  logic  S_AXIS_ACLK,
	input  logic  S_AXIS_ARESETN,
	input  logic  s_axis_tvalid,
	input  logic  s_axis_tlast,
	output logic  s_axis_tready,
	input  logic  space_ok,
	output logic  wr_en,
	output bank_t wr_bank,
	output col_t  wr_col,
	output logic  win_valid,
	output logic  win_last,
	output col_t  win_col,
	output bank_t win_top_bank
);

	localparam int LAST_COL = `NE_ROW_WIDTH - 1;
	localparam int LAST_WIN = `NE_ROW_WIDTH - `NE_KERNEL_SIZE;   // Column of the final window
	localparam int FULL_ROWS = `NE_KERNEL_SIZE - 1;

	logic [1:0] row_count;   // Saturating count of earlier rows in this frame
	logic       row_done;
	logic       queue_pass;
	logic       pass_active;
	logic       pass_busy;
	logic       pass_pending;
	bank_t      pending_top;
	bank_t      new_top;
	logic       row_held;

	assign s_axis_tready = !row_held;
	assign wr_en         = s_axis_tvalid && s_axis_tready;

	// A row closes on its last column, or early on a frame end
	assign row_done   = wr_en && ((wr_col == col_t'(LAST_COL)) || s_axis_tlast);
	assign queue_pass = wr_en && (wr_col == col_t'(LAST_COL))
		&& (row_count == 2'(FULL_ROWS));
	assign new_top    = bank_t'(wr_bank - 2'd2);   // Oldest of the newest three rows

	assign win_valid = pass_active && space_ok;
	assign win_last  = win_valid && (win_col == col_t'(LAST_WIN));
	assign pass_busy = pass_active && !win_last;   // Still reading banks next cycle

	// Input position within the frame
	always_ff @(posedge S_AXIS_ACLK) begin
		if (!S_AXIS_ARESETN) begin
			wr_col    <= '0;
			wr_bank   <= '0;
			row_count <= '0;
		end else if (wr_en) begin
			if (row_done) begin
				wr_col  <= '0;
				wr_bank <= bank_t'(wr_bank + 2'd1);
			end else begin
				wr_col <= col_t'(wr_col + 1'b1);
			end

			if (s_axis_tlast)
				row_count <= '0;   // Next frame starts from scratch
			else if (row_done && row_count != 2'(FULL_ROWS))
				row_count <= row_count + 2'd1;
		end
	end

	// Pass sequencing with one queued pass behind the running one
	always_ff @(posedge S_AXIS_ACLK) begin
		if (!S_AXIS_ARESETN) begin
			pass_active  <= 1'b0;
			pass_pending <= 1'b0;
			pending_top  <= '0;
			win_top_bank <= '0;
			win_col      <= '0;
			row_held     <= 1'b0;
		end else begin
			if (win_valid)
				win_col <= win_last ? '0 : col_t'(win_col + 1'b1);

			if (win_last) begin
				pass_active  <= pass_pending;
				win_top_bank <= pending_top;
				pass_pending <= 1'b0;
				row_held     <= 1'b0;   // Oldest bank of the old pass is free again
			end

			// The next write bank would be the top of the running pass
			if (row_done && pass_busy)
				row_held <= 1'b1;

			if (queue_pass) begin
				if (pass_busy) begin
					pass_pending <= 1'b1;
					pending_top  <= new_top;
				end else begin
					pass_active  <= 1'b1;
					win_top_bank <= new_top;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/ne_cell_pkg.sv
`default_nettype none

`include "ne_settings.svh"

package ne_cell_pkg;

	// Reduction applied to each window
	typedef enum logic {
		CELL_POOL = 1'b0,   // Signed maximum
		CELL_CONV = 1'b1    // Multiply-accumulate with bias
	} cell_mode_t;

	typedef logic signed [`NE_DATA_WIDTH-1:0] coeff_t;   // Kernel tap or bias

	// Same element order as window_t
	typedef coeff_t [`NE_KERNEL_SIZE*`NE_KERNEL_SIZE-1:0] kernel_t;

endpackage

`default_nettype wire

// File: hdl/ne_stream_pkg.sv
`default_nettype none

`include "ne_settings.svh"

package ne_stream_pkg;

	// One signed pixel word
	typedef logic signed [`NE_DATA_WIDTH-1:0] pixel_t;

	// 3x3 window indexed as element r*3+c
	// Row 0 is the oldest row of the pass, column 0 the leftmost pixel
	typedef pixel_t [`NE_KERNEL_SIZE*`NE_KERNEL_SIZE-1:0] window_t;

	typedef logic [$clog2(`NE_ROW_WIDTH)-1:0] col_t;   // Column within a row

	typedef logic [1:0] bank_t;   // Row bank index

endpackage

`default_nettype wire

// File: hdl/ne_settings.svh
`ifndef NE_SETTINGS_SVH
`define NE_SETTINGS_SVH

// Pixel, coefficient and result word
`define NE_DATA_WIDTH 32

// Pixels in one image row
`define NE_ROW_WIDTH 8

`define NE_KERNEL_SIZE 3   // Window edge

// Row memories in the rotation
`define NE_ROW_BANKS 4

`define NE_FIFO_DEPTH 16   // Output FIFO entries

// Registers between window issue and the FIFO write
// (window register, cell stage one, cell stage two)
`define NE_PIPE_DEPTH 3

`endif
